// File: filelist.f
+incdir+test
source/main_bus_pkg.sv
source/main_addr_decode.sv
source/main_ctrl_regs.sv
source/shared_work_ram.sv
source/cpu_wait_gen.sv
source/vblank_irq.sv
source/cpu_read_mux.sv
source/main_bus.sv
test/main_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, then look for the fail message in the log

verilator --binary --timing -Wno-fatal --top-module main_bus_tb \
    -f filelist.f -o main_bus_sim > build.log 2>&1 \
    && ./obj_dir/main_bus_sim > sim.log 2>&1 \
    && ! grep -q "Errors found" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// File: test/main_bus_ref.svh
// Reference model for the main bus testbench: expected ROM address, cabinet byte and value check
`ifndef MAIN_BUS_REF_SVH
`define MAIN_BUS_REF_SVH

// Cabinet inputs and DIP switches as one bundle
typedef struct packed {
    logic [6:0]          joystick1;
    logic [6:0]          joystick2;
    logic [1:0]          start_button;
    logic [1:0]          coin_input;
    main_bus_pkg::byte_t dipsw_a;
    main_bus_pkg::byte_t dipsw_b;
} cab_in_t;

function automatic main_bus_pkg::rom_addr_t expect_rom_addr(
    input main_bus_pkg::addr_t addr,
    input main_bus_pkg::bank_t bank
);
    int block;
    if (addr < 16'h8000) begin
        return main_bus_pkg::rom_addr_t'(addr);   // Fixed low 32 kB
    end
    // 16 kB blocks, bank 0 sits at block ROM_BANK_BASE
    block = int'(main_bus_pkg::ROM_BANK_BASE) + int'(bank);
    return main_bus_pkg::rom_addr_t'(block * 32'h4000 + int'(addr & 16'h3FFF));
endfunction

function automatic main_bus_pkg::byte_t expect_cab(
    input main_bus_pkg::addr_t addr,
    input cab_in_t             inputs
);
    case (addr[2:0])
        3'd0:    return {inputs.coin_input, 4'hF, inputs.start_button};
        3'd1:    return {1'b1, inputs.joystick1};
        3'd2:    return {1'b1, inputs.joystick2};
        3'd3:    return inputs.dipsw_a;
        3'd4:    return inputs.dipsw_b;
        default: return main_bus_pkg::CAB_IDLE;   // Unused port
    endcase
endfunction

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
        errors++;
        $display("ERROR %s: got %0h, expected %0h", name, got, expected);
    end
endtask

`endif

// File: test/main_bus_tb.sv
// Main bus testbench that plays the Z80 and checks decode, latches, RAM, wait and IRQ
`default_nettype none

module main_bus_tb;

    localparam int BUS_OPS = 130;   // Upper bound on bus operations in the sequence
    localparam int TIMEOUT = BUS_OPS * 40 + 2000;

    logic                      clk;
    logic                      rst;
    logic                      cpu_cen = 1'b0;
    main_bus_pkg::cpu_bus_t    bus;
    main_bus_pkg::byte_t       cpu_din;
    logic                      wait_n;
    logic                      int_n;
    logic                      lvbl;
    logic                      blcnten;
    main_bus_pkg::ram_addr_t   obj_addr;
    main_bus_pkg::byte_t       ram_dout;
    main_bus_pkg::byte_t       chr_dout;
    logic                      chr_busy;
    logic                      chr_cs;
    logic                      rom_cs;
    main_bus_pkg::rom_addr_t   rom_addr;
    main_bus_pkg::byte_t       rom_data = 8'h00;
    logic                      rom_ok;
    main_bus_pkg::video_ctrl_t video;
    logic [1:0]                scrposh_cs;
    logic                      okout;
    main_bus_pkg::byte_t       snd_latch;
    logic                      sres_b;
    logic                      dip_pause;

    int                  checks;
    int                  errors;
    int                  seed;
    logic                compare_on;
    main_bus_pkg::bank_t bank_model;
    main_bus_pkg::byte_t ram_copy [0:8191];   // What the work RAM should hold

    `include "main_bus_ref.svh"

    cab_in_t cab;

    main_bus dut (
        .clk          (clk),
        .rst          (rst),
        .cpu_cen      (cpu_cen),
        .bus          (bus),
        .cpu_din      (cpu_din),
        .wait_n       (wait_n),
        .int_n        (int_n),
        .lvbl         (lvbl),
        .blcnten      (blcnten),
        .obj_addr     (obj_addr),
        .ram_dout     (ram_dout),
        .chr_dout     (chr_dout),
        .chr_busy     (chr_busy),
        .chr_cs       (chr_cs),
        .rom_cs       (rom_cs),
        .rom_addr     (rom_addr),
        .rom_data     (rom_data),
        .rom_ok       (rom_ok),
        .video        (video),
        .scrposh_cs   (scrposh_cs),
        .okout        (okout),
        .snd_latch    (snd_latch),
        .sres_b       (sres_b),
        .joystick1    (cab.joystick1),
        .joystick2    (cab.joystick2),
        .start_button (cab.start_button),
        .coin_input   (cab.coin_input),
        .dip_pause    (dip_pause),
        .dipsw_a      (cab.dipsw_a),
        .dipsw_b      (cab.dipsw_b)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst) begin
            cpu_cen <= 1'b0;
        end else begin
            cpu_cen <= ~cpu_cen;   // Every second clk
        end
    end

    ////////////////////////////////////////////////////////////
    // ROM model with one clk of latency

    function automatic main_bus_pkg::byte_t rom_fill(input main_bus_pkg::rom_addr_t a);
        return a[7:0] ^ a[15:8] ^ {a[16], 7'h2B};
    endfunction

    always @(posedge clk) begin
        rom_data <= rom_fill(rom_addr);
    end

    // Select and ROM address compare on every falling edge
    always @(negedge clk) begin
        if (compare_on) begin
            check_value("rom_cs", rom_cs,
                        bus.mreq && !bus.rfsh && bus.addr < 16'hC000);
            check_value("chr_cs", chr_cs,
                        bus.mreq && !bus.rfsh && bus.addr >= 16'hD000
                        && bus.addr <= 16'hD7FF);
            if (bus.mreq && !bus.rfsh && bus.addr < 16'hC000) begin
                check_value("rom_addr", rom_addr, expect_rom_addr(bus.addr, bank_model));
            end
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the test sequence did not finish in time");
        $display("Errors found");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // CPU bus tasks

    function automatic main_bus_pkg::cpu_bus_t make_op(input main_bus_pkg::addr_t a,
                                                       input main_bus_pkg::byte_t d,
                                                       input logic write);
        main_bus_pkg::cpu_bus_t op;
        op      = '0;
        op.addr = a;
        op.dout = d;
        op.mreq = 1'b1;
        op.rd   = !write;
        op.wr   = write;
        return op;
    endfunction

    task automatic cen_edge;   // Advance to the next rising edge with cpu_cen
        @(negedge clk);
        while (!cpu_cen) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic finish_cycle(output main_bus_pkg::byte_t din);
        @(negedge clk);
        while (!(cpu_cen && wait_n)) @(negedge clk);
        din = cpu_din;   // Stable until the cycle ends at the next edge
    endtask

    task automatic bus_cycle(input main_bus_pkg::cpu_bus_t op,
                             output main_bus_pkg::byte_t din);
        cen_edge();
        bus <= op;
        finish_cycle(din);
    endtask

    task automatic write_bus(input main_bus_pkg::addr_t a, input main_bus_pkg::byte_t d);
        main_bus_pkg::byte_t din;
        bus_cycle(make_op(a, d, 1'b1), din);
    endtask

    task automatic read_bus(input main_bus_pkg::addr_t a, output main_bus_pkg::byte_t d);
        bus_cycle(make_op(a, 8'h00, 1'b0), d);
    endtask

    task automatic settle;   // Last write lands and the bus goes idle
        cen_edge();
        bus <= '0;
        @(negedge clk);
    endtask

    task automatic select_probe(input main_bus_pkg::addr_t a, input logic [1:0] exp_h,
                                input logic exp_ok);
        main_bus_pkg::byte_t din;
        cen_edge();
        bus <= make_op(a, 8'h00, 1'b0);
        @(negedge clk);
        check_value("scrposh_cs", scrposh_cs, exp_h);
        check_value("okout", okout, exp_ok);
        finish_cycle(din);
    endtask

    task automatic obj_read(input main_bus_pkg::ram_addr_t a);
        @(posedge clk);
        obj_addr <= a;
        @(posedge clk);
        @(negedge clk);
        check_value("ram_dout", ram_dout, ram_copy[a]);
    endtask

    // Kind 0 holds rom_ok low, 1 holds chr_busy, 2 holds dip_pause low
    task automatic stalled_read(input int kind, input main_bus_pkg::cpu_bus_t op,
                                input main_bus_pkg::byte_t expected);
        int                  len;
        main_bus_pkg::byte_t din;
        len = 2 + int'($unsigned($random(seed)) % 8);
        cen_edge();
        case (kind)
            0:       rom_ok <= 1'b0;
            1:       chr_busy <= 1'b1;
            default: dip_pause <= 1'b0;
        endcase
        cen_edge();   // Pause flag is set by now
        bus <= op;
        repeat (len) begin
            @(negedge clk);
            check_value("wait_n", wait_n, 1'b0);
        end
        @(posedge clk);
        rom_ok    <= 1'b1;
        chr_busy  <= 1'b0;
        dip_pause <= 1'b1;
        finish_cycle(din);
        check_value("cpu_din", din, expected);
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("Test %s: passed", name);
        end else begin
            $display("Test %s: FAILED with %0d errors", name, errors - errs_before);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        int                        errs;
        int                        i;
        logic [63:0]               r64;
        main_bus_pkg::byte_t       d;
        main_bus_pkg::byte_t       rd;
        main_bus_pkg::addr_t       a;
        main_bus_pkg::addr_t       ram_addrs [$];
        main_bus_pkg::video_ctrl_t exp_video;
        main_bus_pkg::cpu_bus_t    op;

        seed       = 23;
        checks     = 0;
        errors     = 0;
        compare_on = 1'b0;
        bank_model = '0;
        rst        = 1'b1;
        bus        = '0;
        lvbl       = 1'b1;
        blcnten    = 1'b0;
        obj_addr   = '0;
        chr_dout   = 8'h00;
        chr_busy   = 1'b0;
        rom_ok     = 1'b1;
        dip_pause  = 1'b1;
        cab        = '1;

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_on = 1'b1;

        // Reset values
        errs = errors;
        exp_video = '{flip: 1'b0, chon: 1'b0, scron: 1'b1, objon: 1'b1, scrposv: 8'h00};
        check_value("video", video, exp_video);
        check_value("bank", dut.bank, 2'd0);
        check_value("snd_latch", snd_latch, 8'h00);
        check_value("sres_b", sres_b, 1'b1);
        check_value("wait_n", wait_n, 1'b1);
        check_value("int_n", int_n, 1'b1);
        end_test("reset", errs);

        // Bank writes to C804 followed by banked ROM reads
        errs = errors;
        for (i = 0; i < 4; i++) begin
            d = 8'($random(seed));
            d[3:2] = i[1:0];
            write_bus(16'hC804, d);
            bank_model = i[1:0];
            settle();
            check_value("flip", video.flip, d[6]);
            check_value("chon", video.chon, d[7]);
            check_value("sres_b", sres_b, !d[5]);
            check_value("bank", dut.bank, i[1:0]);
            repeat (4) begin
                a = 16'($unsigned($random(seed)) % 32'hC000);
                read_bus(a, rd);
                check_value("cpu_din", rd, rom_fill(expect_rom_addr(a, bank_model)));
            end
        end
        end_test("rom banking", errs);

        // Video and sound latches and strobe selects
        errs = errors;
        d = 8'($random(seed));
        write_bus(16'hC800, d);
        settle();
        check_value("snd_latch", snd_latch, d);
        d = 8'($random(seed));
        write_bus(16'hD802, d);
        settle();
        check_value("scrposv", video.scrposv, d);
        d = 8'($random(seed));
        write_bus(16'hD806, d);
        settle();
        check_value("objon", video.objon, d[5]);
        check_value("scron", video.scron, d[4]);
        select_probe(16'hD800, 2'b01, 1'b0);
        select_probe(16'hD801, 2'b10, 1'b0);
        select_probe(16'hC806, 2'b00, 1'b1);
        end_test("control latches", errs);

        // Work RAM from the CPU and then from the object side
        errs = errors;
        for (i = 0; i < 12; i++) begin
            a = 16'hE000 | 16'($unsigned($random(seed)) & 32'h1FFF);
            d = 8'($random(seed));
            write_bus(a, d);
            ram_copy[a[12:0]] = d;
            ram_addrs.push_back(a);
        end
        for (i = 0; i < ram_addrs.size(); i++) begin
            read_bus(ram_addrs[i], rd);
            check_value("cpu_din", rd, ram_copy[ram_addrs[i][12:0]]);
        end
        settle();
        @(posedge clk);
        blcnten <= 1'b1;
        for (i = 0; i < ram_addrs.size(); i++) begin
            obj_read(ram_addrs[i][12:0]);
        end
        for (i = 0; i < 4; i++) begin   // These writes must be dropped
            @(posedge clk);
            obj_addr <= ram_addrs[i][12:0];
            write_bus(ram_addrs[i], ~ram_copy[ram_addrs[i][12:0]]);
        end
        settle();
        for (i = 0; i < 4; i++) begin
            obj_read(ram_addrs[i][12:0]);
        end
        @(posedge clk);
        blcnten <= 1'b0;
        for (i = 0; i < 4; i++) begin
            read_bus(ram_addrs[i], rd);
            check_value("cpu_din", rd, ram_copy[ram_addrs[i][12:0]]);
        end
        end_test("work ram", errs);

        // Cabinet ports and wait sources
        errs = errors;
        for (i = 0; i < 8; i++) begin
            r64 = {$random(seed), $random(seed)};
            cen_edge();
            cab <= r64[33:0];
            a = 16'hC000 | 16'(i);
            read_bus(a, rd);
            check_value("cpu_din", rd, expect_cab(a, cab));
        end
        a = 16'($unsigned($random(seed)) % 32'hC000);
        stalled_read(0, make_op(a, 8'h00, 1'b0), rom_fill(expect_rom_addr(a, bank_model)));
        d = 8'($random(seed));
        cen_edge();
        chr_dout <= d;
        a = 16'hD000 | 16'($unsigned($random(seed)) & 32'h07FF);
        stalled_read(1, make_op(a, 8'h00, 1'b0), d);
        a = 16'($unsigned($random(seed)) % 32'hC000);
        stalled_read(2, make_op(a, 8'h00, 1'b0), rom_fill(expect_rom_addr(a, bank_model)));
        end_test("inputs and wait", errs);

        // Vertical-blank interrupt and acknowledge
        errs = errors;
        cen_edge();
        lvbl <= 1'b0;
        settle();
        check_value("int_n", int_n, 1'b0);
        op      = '0;
        op.iorq = 1'b1;
        op.m1   = 1'b1;
        bus_cycle(op, rd);
        check_value("cpu_din", rd, main_bus_pkg::IRQ_VECTOR);
        settle();
        check_value("int_n", int_n, 1'b1);
        end_test("vblank irq", errs);

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/main_bus.sv
// Main CPU bus subsystem top: decode, latches, work RAM, wait, interrupt and read mux
`default_nettype none

module main_bus (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       cpu_cen,
    // CPU side
    input  main_bus_pkg::cpu_bus_t    bus,
    output main_bus_pkg::byte_t       cpu_din,
    output logic                      wait_n,
    output logic                      int_n,
    // Timing and object scan
    input  wire                       lvbl,
    input  wire                       blcnten,
    input  main_bus_pkg::ram_addr_t   obj_addr,
    output main_bus_pkg::byte_t       ram_dout,
    // Character RAM
    input  main_bus_pkg::byte_t       chr_dout,
    input  wire                       chr_busy,
    output logic                      chr_cs,
    // ROM
    output logic                      rom_cs,
    output main_bus_pkg::rom_addr_t   rom_addr,
    input  main_bus_pkg::byte_t       rom_data,
    input  wire                       rom_ok,
    // Video and sound control
    output main_bus_pkg::video_ctrl_t video,
    output logic [1:0]                scrposh_cs,
    output logic                      okout,
    output main_bus_pkg::byte_t       snd_latch,
    output logic                      sres_b,
    // Cabinet and DIP switches
    input  wire [6:0]                 joystick1,
    input  wire [6:0]                 joystick2,
    input  wire [1:0]                 start_button,
    input  wire [1:0]                 coin_input,
    input  wire                       dip_pause,
    input  main_bus_pkg::byte_t       dipsw_a,
    input  main_bus_pkg::byte_t       dipsw_b
);

    main_bus_pkg::chip_sel_t sel;
    main_bus_pkg::bank_t     bank;
    logic                    irq_ack;

    assign rom_cs     = sel.rom;
    assign chr_cs     = sel.chr;
    assign scrposh_cs = sel.scrposh;
    assign okout      = sel.okout;

    main_addr_decode u_decode (
        .bus      (bus),
        .bank     (bank),
        .sel      (sel),
        .rom_addr (rom_addr)
    );

    main_ctrl_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .cpu_cen   (cpu_cen),
        .bus       (bus),
        .sel       (sel),
        .video     (video),
        .bank      (bank),
        .snd_latch (snd_latch),
        .sres_b    (sres_b)
    );

    shared_work_ram u_ram (
        .clk      (clk),
        .cpu_cen  (cpu_cen),
        .blcnten  (blcnten),
        .cpu_addr (bus.addr[12:0]),
        .obj_addr (obj_addr),
        .din      (bus.dout),
        .we       (sel.ram && bus.wr),
        .dout     (ram_dout)
    );

    cpu_wait_gen u_wait (
        .clk       (clk),
        .rst       (rst),
        .cpu_cen   (cpu_cen),
        .sel       (sel),
        .rom_ok    (rom_ok),
        .chr_busy  (chr_busy),
        .dip_pause (dip_pause),
        .wait_n    (wait_n)
    );

    vblank_irq u_irq (
        .clk     (clk),
        .rst     (rst),
        .cpu_cen (cpu_cen),
        .lvbl    (lvbl),
        .irq_ack (irq_ack),
        .int_n   (int_n)
    );

    cpu_read_mux u_rdmux (
        .bus          (bus),
        .sel          (sel),
        .ram_dout     (ram_dout),
        .chr_dout     (chr_dout),
        .rom_data     (rom_data),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .cpu_din      (cpu_din),
        .irq_ack      (irq_ack)
    );

endmodule

`default_nettype wire

// File: source/cpu_read_mux.sv
// CPU read data mux: interrupt vector, RAMs, cabinet ports and ROM
`default_nettype none

module cpu_read_mux (
    input  main_bus_pkg::cpu_bus_t  bus,
    input  main_bus_pkg::chip_sel_t sel,
    input  main_bus_pkg::byte_t     ram_dout,
    input  main_bus_pkg::byte_t     chr_dout,
    input  main_bus_pkg::byte_t     rom_data,
    input  wire [6:0]               joystick1,
    input  wire [6:0]               joystick2,
    input  wire [1:0]               start_button,
    input  wire [1:0]               coin_input,
    input  main_bus_pkg::byte_t     dipsw_a,
    input  main_bus_pkg::byte_t     dipsw_b,
    output main_bus_pkg::byte_t     cpu_din,
    output logic                    irq_ack
);

    main_bus_pkg::byte_t cab_byte;

    assign irq_ack = bus.iorq && bus.m1;

    ////////////////////////////////////////////////////////////
    // Cabinet input ports

    always_comb begin
        case (bus.addr[2:0])
            3'd0:    cab_byte = {coin_input, 4'b1111, start_button};
            3'd1:    cab_byte = {1'b1, joystick1};
            3'd2:    cab_byte = {1'b1, joystick2};
            3'd3:    cab_byte = dipsw_a;
            3'd4:    cab_byte = dipsw_b;
            default: cab_byte = main_bus_pkg::CAB_IDLE;
        endcase
    end

    always_comb begin
        if (irq_ack) begin
            cpu_din = main_bus_pkg::IRQ_VECTOR;   // Mode 0 vector
        end else if (sel.ram) begin
            cpu_din = ram_dout;
        end else if (sel.chr) begin
            cpu_din = chr_dout;
        end else if (sel.cab) begin
            cpu_din = cab_byte;
        end else begin
            cpu_din = rom_data;   // Also the idle bus value
        end
    end

endmodule

`default_nettype wire

// File: source/vblank_irq.sv
// Vertical-blank interrupt: set on the falling edge of lvbl, cleared on acknowledge
`default_nettype none

module vblank_irq (
    input  wire  clk,
    input  wire  rst,
    input  wire  cpu_cen,
    input  wire  lvbl,
    input  wire  irq_ack,
    output logic int_n
);

    logic lvbl_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            lvbl_last <= 1'b0;
            int_n     <= 1'b1;
        end else if (cpu_cen) begin
            lvbl_last <= lvbl;
            if (irq_ack) begin
                int_n <= 1'b1;
            end else if (lvbl_last && !lvbl) begin
                int_n <= 1'b0;   // Blank starts
            end
        end
    end

endmodule

`default_nettype wire

// File: source/cpu_wait_gen.sv
// CPU wait generator: stalls on pending ROM data, busy character RAM or pause
`default_nettype none

module cpu_wait_gen (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     cpu_cen,
    input  main_bus_pkg::chip_sel_t sel,
    input  wire                     rom_ok,
    input  wire                     chr_busy,
    input  wire                     dip_pause,
    output logic                    wait_n
);

    logic pause;
    logic rom_wait;
    logic chr_wait;

    always_ff @(posedge clk) begin
        if (rst) begin
            pause <= 1'b0;
        end else if (cpu_cen) begin
            pause <= ~dip_pause;   // Switch is active low
        end
    end

    // SDRAM data not back yet
    assign rom_wait = sel.rom && !rom_ok;
    // Video side holds the character RAM
    assign chr_wait = sel.chr && chr_busy;

    assign wait_n = !(rom_wait || chr_wait || pause);

endmodule

`default_nettype wire

// File: source/shared_work_ram.sv
// Work RAM, 8 kB, shared between the CPU and the object line scan
`default_nettype none

module shared_work_ram (
    input  wire                     clk,
    input  wire                     cpu_cen,
    input  wire                     blcnten,
    input  main_bus_pkg::ram_addr_t cpu_addr,
    input  main_bus_pkg::ram_addr_t obj_addr,
    input  main_bus_pkg::byte_t     din,
    input  wire                     we,
    output main_bus_pkg::byte_t     dout
);

    main_bus_pkg::byte_t     mem [0:8191];
    main_bus_pkg::ram_addr_t addr;
    logic                    ram_we;

    // Object engine owns the RAM during line scan
    assign addr   = blcnten ? obj_addr : cpu_addr;
    assign ram_we = !blcnten && we && cpu_cen;   // CPU writes dropped while scanning

    always_ff @(posedge clk) begin
        if (ram_we) mem[addr] <= din;
        dout <= mem[addr];   // Read every clk
    end

endmodule

`default_nettype wire

// File: source/main_ctrl_regs.sv
// Control latches written by the CPU: video enables, scroll, sound and ROM bank
`default_nettype none

module main_ctrl_regs (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       cpu_cen,
    input  main_bus_pkg::cpu_bus_t    bus,
    input  main_bus_pkg::chip_sel_t   sel,
    output main_bus_pkg::video_ctrl_t video,
    output main_bus_pkg::bank_t       bank,
    output main_bus_pkg::byte_t       snd_latch,
    output logic                      sres_b
);

    logic wr_cyc;   // Write strobe qualified by the CPU clock enable

    assign wr_cyc = cpu_cen && bus.wr;

    always_ff @(posedge clk) begin
        if (rst) begin
            video.flip    <= 1'b0;
            video.chon    <= 1'b0;
            video.scron   <= 1'b1;
            video.objon   <= 1'b1;
            video.scrposv <= '0;
            bank          <= '0;
            snd_latch     <= '0;
            sres_b        <= 1'b1;   // Sound CPU running
        end else if (wr_cyc) begin
            if (sel.misc) begin
                video.chon <= bus.dout[main_bus_pkg::MISC_CHON_BIT];
                video.flip <= bus.dout[main_bus_pkg::MISC_FLIP_BIT];
                sres_b     <= ~bus.dout[main_bus_pkg::MISC_SRES_BIT];
                bank       <= bus.dout[main_bus_pkg::MISC_BANK_LSB +: 2];
            end
            if (sel.snd_latch) snd_latch <= bus.dout;
            if (sel.scrposv) video.scrposv <= bus.dout;
            if (sel.gfxen) begin
                video.objon <= bus.dout[main_bus_pkg::GFX_OBJON_BIT];
                video.scron <= bus.dout[main_bus_pkg::GFX_SCRON_BIT];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/main_addr_decode.sv
// Address decoder: Z80 memory map to chip selects and banked ROM address
`default_nettype none

module main_addr_decode (
    input  main_bus_pkg::cpu_bus_t  bus,
    input  main_bus_pkg::bank_t     bank,
    output main_bus_pkg::chip_sel_t sel,
    output main_bus_pkg::rom_addr_t rom_addr
);

    logic page_low;   // Offset within an I/O page below 0010

    assign page_low = (bus.addr[10:4] == 7'd0);

    always_comb begin
        sel = '0;
        if (bus.mreq && !bus.rfsh) begin   // No decode during refresh
            casez (bus.addr[15:11])
                5'b0????, 5'b10???: sel.rom = 1'b1;   // 48 kB
                5'b11000: sel.cab = 1'b1;             // C000-C7FF
                5'b11001: begin                       // C800 page
                    if (page_low) begin
                        case (bus.addr[3:0])
                            main_bus_pkg::OFS_SND_LATCH: sel.snd_latch = 1'b1;
                            main_bus_pkg::OFS_MISC:      sel.misc      = 1'b1;
                            main_bus_pkg::OFS_OKOUT:     sel.okout     = 1'b1;
                            default: ;
                        endcase
                    end
                end
                5'b11010: sel.chr = 1'b1;             // D000-D7FF
                5'b11011: begin                       // D800 page
                    if (page_low) begin
                        case (bus.addr[3:0])
                            4'h0, 4'h1:
                                sel.scrposh[bus.addr[0]] = 1'b1;
                            main_bus_pkg::OFS_SCRPOSV: sel.scrposv = 1'b1;
                            main_bus_pkg::OFS_GFXEN:   sel.gfxen   = 1'b1;
                            default: ;
                        endcase
                    end
                end
                5'b111??: sel.ram = 1'b1;             // E000-FFFF
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // ROM address: 32 kB fixed, then 16 kB banks

    always_comb begin
        if (!bus.addr[15]) begin
            rom_addr = {1'b0, bus.addr};
        end else begin
            rom_addr = {main_bus_pkg::ROM_BANK_BASE + {1'b0, bank}, bus.addr[13:0]};
        end
    end

endmodule

`default_nettype wire

// File: source/main_bus_pkg.sv
// Main CPU bus package: widths, bus structs, register fields and map constants
`default_nettype none

package main_bus_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [16:0] rom_addr_t;
    typedef logic [12:0] ram_addr_t;
    typedef logic [1:0]  bank_t;

    // What the CPU drives, strobes active high
    typedef struct packed {
        addr_t addr;
        byte_t dout;
        logic  mreq;
        logic  rfsh;
        logic  rd;
        logic  wr;
        logic  iorq;
        logic  m1;
    } cpu_bus_t;

    typedef struct packed {
        logic       rom;
        logic       ram;
        logic       cab;
        logic       chr;
        logic       snd_latch;
        logic       misc;
        logic       scrposv;
        logic       gfxen;
        logic       okout;
        logic [1:0] scrposh;
    } chip_sel_t;

    typedef struct packed {
        logic  flip;
        logic  chon;
        logic  scron;
        logic  objon;
        byte_t scrposv;
    } video_ctrl_t;

    ////////////////////////////////////////////////////////////
    // Register fields
    localparam int MISC_CHON_BIT  = 7;
    localparam int MISC_FLIP_BIT  = 6;
    localparam int MISC_SRES_BIT  = 5;   // Sound reset, inverted on the board
    localparam int MISC_BANK_LSB  = 2;
    localparam int GFX_OBJON_BIT  = 5;
    localparam int GFX_SCRON_BIT  = 4;

    ////////////////////////////////////////////////////////////
    // Memory map, low nibble inside the C8xx and D8xx pages
    localparam logic [3:0] OFS_SND_LATCH = 4'h0;
    localparam logic [3:0] OFS_MISC      = 4'h4;
    localparam logic [3:0] OFS_OKOUT     = 4'h6;
    localparam logic [3:0] OFS_SCRPOSV   = 4'h2;
    localparam logic [3:0] OFS_GFXEN     = 4'h6;

    localparam logic [2:0] ROM_BANK_BASE = 3'd2;  // First 16 kB block of bank 0
    localparam byte_t      IRQ_VECTOR    = 8'hD7; // RST 10h
    localparam byte_t      CAB_IDLE      = 8'hFF;

endpackage

`default_nettype wire
